// File: src/core101_defines.svh
// Shared widths, reset PC and RV32I field layout
// Only the OP, OP-IMM, LUI and AUIPC major opcodes are listed
`ifndef CORE101_DEFINES_SVH
`define CORE101_DEFINES_SVH

`define CORE101_XLEN        32            // Data and PC width
`define CORE101_REG_ADDR_W  5             // x0..x31
`define CORE101_REG_COUNT   32
`define CORE101_RESET_PC    32'h0000_0000
`define CORE101_PC_STEP     32'd4         // No compressed instructions

// Major opcodes
`define CORE101_OPC_OP      7'b0110011
`define CORE101_OPC_OP_IMM  7'b0010011
`define CORE101_OPC_LUI     7'b0110111
`define CORE101_OPC_AUIPC   7'b0010111

// Instruction field positions
`define CORE101_OPCODE_RANGE 6:0
`define CORE101_RD_RANGE     11:7
`define CORE101_FUNCT3_RANGE 14:12
`define CORE101_RS1_RANGE    19:15
`define CORE101_RS2_RANGE    24:20
`define CORE101_FUNCT7_RANGE 31:25

`define CORE101_NOP          32'h0000_0013 // addi x0,x0,0

`endif

// File: src/core101_pkg.sv
// Enums shared by the pipeline stages
// Opcode values come from the defines header

`include "core101_defines.svh"

package core101_pkg;

  // Supported major opcodes, anything else decodes to a bubble
  typedef enum logic [6:0] {
    OPC_OP     = `CORE101_OPC_OP,
    OPC_OP_IMM = `CORE101_OPC_OP_IMM,
    OPC_LUI    = `CORE101_OPC_LUI,
    OPC_AUIPC  = `CORE101_OPC_AUIPC
  } opcode_e;

  // Integer ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND  // Last legal code
  } alu_op_e;

  // Where an operand picks up the writeback bus
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_AT_ISSUE, // Producer two ahead
    FWD_AT_EXEC   // Producer one ahead
  } fwd_sel_e;

endpackage

// File: src/fetch_unit.sv
// PC register and IF/ID register
// Instruction port is read combinationally from imem_addr
// Halt freezes the PC and pushes bubbles, no other stall source

`timescale 1ns/10ps
`include "core101_defines.svh"

module fetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     halt,      // Level, sampled every edge
  input  logic [`CORE101_XLEN-1:0] imem_data,
  output logic [`CORE101_XLEN-1:0] imem_addr,
  output logic                     if_valid,
  output logic [`CORE101_XLEN-1:0] if_instr,
  output logic [`CORE101_XLEN-1:0] if_pc
);

  logic [`CORE101_XLEN-1:0] pc;

  assign imem_addr = pc;

  // PC and valid bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= `CORE101_RESET_PC;
      if_valid <= 1'b0;
    end else begin
      if_valid <= !halt;                         // Bubble while halted
      if (!halt) pc <= pc + `CORE101_PC_STEP;    // Hold otherwise
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if_instr <= halt ? `CORE101_NOP : imem_data;
    if_pc    <= pc;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    imem_addr[1:0] == 2'b00);

endmodule

// File: src/gpr_file.sv
// 32 x 32 register file, two read ports and one write port
// Reads are combinational and see a same-cycle write
// x0 reads zero and ignores writes

`timescale 1ns/10ps
`include "core101_defines.svh"

module gpr_file (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [`CORE101_REG_ADDR_W-1:0] rs1_addr,
  input  logic [`CORE101_REG_ADDR_W-1:0] rs2_addr,
  output logic [`CORE101_XLEN-1:0]       rs1_data,
  output logic [`CORE101_XLEN-1:0]       rs2_data,
  input  logic                           wr_en,
  input  logic [`CORE101_REG_ADDR_W-1:0] wr_addr,
  input  logic [`CORE101_XLEN-1:0]       wr_data
);

  logic [`CORE101_XLEN-1:0] regs [`CORE101_REG_COUNT];
  logic                     wr_live;  // Real write this cycle

  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CORE101_REG_COUNT; i++) regs[i] <= '0;
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write-through covers the distance-3 producer
  assign rs1_data = (wr_live && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
  assign rs2_data = (wr_live && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

// File: src/forward_unit.sv
// Hazard detection for producers one and two stages ahead
// Distance three is left to the write-through register file

`timescale 1ns/10ps
`include "core101_defines.svh"

module forward_unit (
  input  logic [`CORE101_REG_ADDR_W-1:0] rs1_addr,
  input  logic [`CORE101_REG_ADDR_W-1:0] rs2_addr,
  input  logic                           a_is_pc,   // A is the PC, never forwarded
  input  logic                           b_is_imm,  // B is the immediate
  input  logic                           is_valid,  // ID/IS entry, distance 1
  input  logic                           is_we,
  input  logic [`CORE101_REG_ADDR_W-1:0] is_rd,
  input  logic                           ex_valid,  // IS/EX entry, distance 2
  input  logic                           ex_we,
  input  logic [`CORE101_REG_ADDR_W-1:0] ex_rd,
  output core101_pkg::fwd_sel_e          fwd_a,
  output core101_pkg::fwd_sel_e          fwd_b
);

  // Nearer producer wins
  function automatic core101_pkg::fwd_sel_e pick(
    input logic [`CORE101_REG_ADDR_W-1:0] rs,
    input logic                           skip
  );
    if (skip || rs == '0)                              return core101_pkg::FWD_NONE;
    else if (is_valid && is_we && is_rd == rs)         return core101_pkg::FWD_AT_EXEC;
    else if (ex_valid && ex_we && ex_rd == rs)         return core101_pkg::FWD_AT_ISSUE;
    else                                               return core101_pkg::FWD_NONE;
  endfunction

  assign fwd_a = pick(rs1_addr, a_is_pc);
  assign fwd_b = pick(rs2_addr, b_is_imm);

endmodule

// File: src/decode_stage.sv
// Opcode decode, immediates, register read and the ID/IS register
// Unknown opcodes become bubbles and raise no exception
// LUI reads x0 as operand A so the ALU just adds

`timescale 1ns/10ps
`include "core101_defines.svh"

module decode_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           if_valid,
  input  logic [`CORE101_XLEN-1:0]       if_instr,
  input  logic [`CORE101_XLEN-1:0]       if_pc,
  output logic [`CORE101_REG_ADDR_W-1:0] rs1_addr,   // To gpr_file
  output logic [`CORE101_REG_ADDR_W-1:0] rs2_addr,
  input  logic [`CORE101_XLEN-1:0]       rs1_data,
  input  logic [`CORE101_XLEN-1:0]       rs2_data,
  input  logic                           ex_valid,   // IS/EX producer
  input  logic                           ex_we,
  input  logic [`CORE101_REG_ADDR_W-1:0] ex_rd,
  output logic                           id_valid,
  output logic                           id_we,
  output logic [`CORE101_REG_ADDR_W-1:0] id_rd,
  output logic [`CORE101_XLEN-1:0]       id_pc,
  output logic [`CORE101_XLEN-1:0]       id_rs1_val,
  output logic [`CORE101_XLEN-1:0]       id_rs2_val,
  output logic [`CORE101_XLEN-1:0]       id_imm,
  output logic                           id_a_is_pc,
  output logic                           id_b_is_imm,
  output core101_pkg::alu_op_e           id_alu_op,
  output core101_pkg::fwd_sel_e          id_fwd_a,
  output core101_pkg::fwd_sel_e          id_fwd_b
);

  core101_pkg::opcode_e  opcode;
  core101_pkg::alu_op_e  alu_op;
  core101_pkg::fwd_sel_e fwd_a, fwd_b;
  logic [`CORE101_XLEN-1:0] imm_i, imm_u, imm;
  logic [2:0] funct3;
  logic       alt;       // Selects sub and sra
  logic       dec_ok, a_is_pc, b_is_imm, use_rs1;

  assign opcode = core101_pkg::opcode_e'(if_instr[`CORE101_OPCODE_RANGE]);
  assign funct3 = if_instr[`CORE101_FUNCT3_RANGE];
  assign alt    = if_instr[`CORE101_FUNCT7_RANGE] == 7'b0100000;
  assign imm_i  = {{20{if_instr[31]}}, if_instr[31:20]};
  assign imm_u  = {if_instr[31:12], 12'b0};

  // ------------------------------------------------------------
  // Opcode and funct decode
  // ------------------------------------------------------------
  always_comb begin
    dec_ok   = 1'b1;
    a_is_pc  = 1'b0;
    b_is_imm = 1'b1;
    use_rs1  = 1'b1;
    imm      = imm_i;
    case (funct3)
      3'b000:  alu_op = (alt && opcode == core101_pkg::OPC_OP) ?
                        core101_pkg::ALU_SUB : core101_pkg::ALU_ADD;  // addi has no sub
      3'b001:  alu_op = core101_pkg::ALU_SLL;
      3'b010:  alu_op = core101_pkg::ALU_SLT;
      3'b011:  alu_op = core101_pkg::ALU_SLTU;
      3'b100:  alu_op = core101_pkg::ALU_XOR;
      3'b101:  alu_op = alt ? core101_pkg::ALU_SRA : core101_pkg::ALU_SRL;
      3'b110:  alu_op = core101_pkg::ALU_OR;
      default: alu_op = core101_pkg::ALU_AND;
    endcase
    case (opcode)
      core101_pkg::OPC_OP:     b_is_imm = 1'b0;
      core101_pkg::OPC_OP_IMM: ;                        // Defaults fit
      core101_pkg::OPC_LUI: begin
        use_rs1 = 1'b0;
        imm     = imm_u;
        alu_op  = core101_pkg::ALU_ADD;
      end
      core101_pkg::OPC_AUIPC: begin
        a_is_pc = 1'b1;
        imm     = imm_u;
        alu_op  = core101_pkg::ALU_ADD;
      end
      default: dec_ok = 1'b0;                           // Bubble
    endcase
  end

  assign rs1_addr = use_rs1 ? if_instr[`CORE101_RS1_RANGE] : '0;
  assign rs2_addr = if_instr[`CORE101_RS2_RANGE];

  forward_unit u_fwd (
    .rs1_addr (rs1_addr),  .rs2_addr (rs2_addr),
    .a_is_pc  (a_is_pc),   .b_is_imm (b_is_imm),
    .is_valid (id_valid),  .is_we    (id_we),    .is_rd (id_rd),
    .ex_valid (ex_valid),  .ex_we    (ex_we),    .ex_rd (ex_rd),
    .fwd_a    (fwd_a),     .fwd_b    (fwd_b)
  );

  // ID/IS register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_valid <= 1'b0;
      id_we    <= 1'b0;
    end else begin
      id_valid <= if_valid && dec_ok;
      id_we    <= dec_ok;                      // Every kept opcode writes rd
    end
  end

  always_ff @(posedge clk) begin
    id_rd       <= if_instr[`CORE101_RD_RANGE];
    id_pc       <= if_pc;
    id_rs1_val  <= rs1_data;
    id_rs2_val  <= rs2_data;
    id_imm      <= imm;
    id_a_is_pc  <= a_is_pc;
    id_b_is_imm <= b_is_imm;
    id_alu_op   <= alu_op;
    id_fwd_a    <= fwd_a;
    id_fwd_b    <= fwd_b;
  end

  a_legal_alu_op: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid |-> id_alu_op inside {[core101_pkg::ALU_ADD : core101_pkg::ALU_AND]});

endmodule

// File: src/issue_stage.sv
// Issue-point forwarding, operand muxes and the IS/EX register
// Only at_exec selects travel on to execute

`timescale 1ns/10ps
`include "core101_defines.svh"

module issue_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           id_valid,
  input  logic                           id_we,
  input  logic [`CORE101_REG_ADDR_W-1:0] id_rd,
  input  logic [`CORE101_XLEN-1:0]       id_pc,
  input  logic [`CORE101_XLEN-1:0]       id_rs1_val,
  input  logic [`CORE101_XLEN-1:0]       id_rs2_val,
  input  logic [`CORE101_XLEN-1:0]       id_imm,
  input  logic                           id_a_is_pc,
  input  logic                           id_b_is_imm,
  input  core101_pkg::alu_op_e           id_alu_op,
  input  core101_pkg::fwd_sel_e          id_fwd_a,
  input  core101_pkg::fwd_sel_e          id_fwd_b,
  input  logic                           wb_valid,
  input  logic [`CORE101_REG_ADDR_W-1:0] wb_rd,
  input  logic [`CORE101_XLEN-1:0]       wb_data,
  output logic                           ex_valid,
  output logic                           ex_we,
  output logic [`CORE101_REG_ADDR_W-1:0] ex_rd,
  output logic [`CORE101_XLEN-1:0]       ex_pc,
  output logic [`CORE101_XLEN-1:0]       ex_a,
  output logic [`CORE101_XLEN-1:0]       ex_b,
  output core101_pkg::alu_op_e           ex_alu_op,
  output core101_pkg::fwd_sel_e          ex_fwd_a,
  output core101_pkg::fwd_sel_e          ex_fwd_b
);

  logic [`CORE101_XLEN-1:0] rs1_val, rs2_val;

  // Producer two ahead sits in EX/WB now
  assign rs1_val = (id_fwd_a == core101_pkg::FWD_AT_ISSUE) ? wb_data : id_rs1_val;
  assign rs2_val = (id_fwd_b == core101_pkg::FWD_AT_ISSUE) ? wb_data : id_rs2_val;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_we    <= 1'b0;
    end else begin
      ex_valid <= id_valid;
      ex_we    <= id_we;
    end
  end

  always_ff @(posedge clk) begin
    ex_rd     <= id_rd;
    ex_pc     <= id_pc;
    ex_a      <= id_a_is_pc  ? id_pc  : rs1_val;   // AUIPC
    ex_b      <= id_b_is_imm ? id_imm : rs2_val;
    ex_alu_op <= id_alu_op;
    ex_fwd_a  <= (id_fwd_a == core101_pkg::FWD_AT_EXEC) ? id_fwd_a : core101_pkg::FWD_NONE;
    ex_fwd_b  <= (id_fwd_b == core101_pkg::FWD_AT_EXEC) ? id_fwd_b : core101_pkg::FWD_NONE;
  end

  // An at_issue mark made in decode must meet a real retirement here
  a_issue_fwd_src: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid && (id_fwd_a == core101_pkg::FWD_AT_ISSUE ||
                 id_fwd_b == core101_pkg::FWD_AT_ISSUE) |-> wb_valid && wb_rd != '0);

endmodule

// File: src/exec_stage.sv
// Execute-point forwarding, integer ALU and the EX/WB register
// EX/WB output doubles as the writeback bus and the forward source

`timescale 1ns/10ps
`include "core101_defines.svh"

module exec_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           ex_valid,
  input  logic                           ex_we,
  input  logic [`CORE101_REG_ADDR_W-1:0] ex_rd,
  input  logic [`CORE101_XLEN-1:0]       ex_pc,
  input  logic [`CORE101_XLEN-1:0]       ex_a,
  input  logic [`CORE101_XLEN-1:0]       ex_b,
  input  core101_pkg::alu_op_e           ex_alu_op,
  input  core101_pkg::fwd_sel_e          ex_fwd_a,
  input  core101_pkg::fwd_sel_e          ex_fwd_b,
  output logic                           wb_valid,  // Only non-zero rd
  output logic [`CORE101_REG_ADDR_W-1:0] wb_rd,
  output logic [`CORE101_XLEN-1:0]       wb_data,
  output logic [`CORE101_XLEN-1:0]       wb_pc
);

  logic [`CORE101_XLEN-1:0] op_a, op_b, alu_res;
  logic [4:0]               shamt;

  // Producer one ahead is in our own output register
  assign op_a  = (ex_fwd_a == core101_pkg::FWD_AT_EXEC) ? wb_data : ex_a;
  assign op_b  = (ex_fwd_b == core101_pkg::FWD_AT_EXEC) ? wb_data : ex_b;
  assign shamt = op_b[4:0];

  // ------------------------------------------------------------
  // Integer ALU
  // ------------------------------------------------------------
  always_comb begin
    case (ex_alu_op)
      core101_pkg::ALU_ADD:  alu_res = op_a + op_b;
      core101_pkg::ALU_SUB:  alu_res = op_a - op_b;
      core101_pkg::ALU_SLL:  alu_res = op_a << shamt;
      core101_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
      core101_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
      core101_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      core101_pkg::ALU_SRL:  alu_res = op_a >> shamt;
      core101_pkg::ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
      core101_pkg::ALU_OR:   alu_res = op_a | op_b;
      default:               alu_res = op_a & op_b;
    endcase
  end

  // EX/WB register
  always_ff @(posedge clk) begin
    if (!rst_n) wb_valid <= 1'b0;
    else        wb_valid <= ex_valid && ex_we && (ex_rd != '0);
  end

  always_ff @(posedge clk) begin
    wb_rd   <= ex_rd;
    wb_data <= alu_res;
    wb_pc   <= ex_pc;
  end

  // Pipeline never stalls past fetch, so the distance-1 producer is retiring now
  a_exec_fwd_src: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid && (ex_fwd_a == core101_pkg::FWD_AT_EXEC ||
                 ex_fwd_b == core101_pkg::FWD_AT_EXEC) |-> wb_valid);

endmodule

// File: src/core101_top.sv
// Five-stage in-order RV32I integer core, ALU groups plus LUI and AUIPC
// No loads, stores or branches; unknown opcodes retire nothing
// Retirements that write a non-zero rd show on the wb_* port

`timescale 1ns/10ps
`include "core101_defines.svh"

module core101_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           halt,
  input  logic [`CORE101_XLEN-1:0]       imem_data,
  output logic [`CORE101_XLEN-1:0]       imem_addr,
  output logic                           wb_valid,
  output logic [`CORE101_REG_ADDR_W-1:0] wb_rd,
  output logic [`CORE101_XLEN-1:0]       wb_data,
  output logic [`CORE101_XLEN-1:0]       wb_pc
);

  // IF/ID
  logic                           if_valid;
  logic [`CORE101_XLEN-1:0]       if_instr, if_pc;
  // Register file ports
  logic [`CORE101_REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [`CORE101_XLEN-1:0]       rs1_data, rs2_data;
  // ID/IS
  logic                           id_valid, id_we, id_a_is_pc, id_b_is_imm;
  logic [`CORE101_REG_ADDR_W-1:0] id_rd;
  logic [`CORE101_XLEN-1:0]       id_pc, id_rs1_val, id_rs2_val, id_imm;
  core101_pkg::alu_op_e           id_alu_op;
  core101_pkg::fwd_sel_e          id_fwd_a, id_fwd_b;
  // IS/EX
  logic                           ex_valid, ex_we;
  logic [`CORE101_REG_ADDR_W-1:0] ex_rd;
  logic [`CORE101_XLEN-1:0]       ex_pc, ex_a, ex_b;
  core101_pkg::alu_op_e           ex_alu_op;
  core101_pkg::fwd_sel_e          ex_fwd_a, ex_fwd_b;

  fetch_unit u_fetch (
    .clk (clk), .rst_n (rst_n), .halt (halt),
    .imem_data (imem_data), .imem_addr (imem_addr),
    .if_valid (if_valid), .if_instr (if_instr), .if_pc (if_pc)
  );

  gpr_file u_gpr (       // Written straight from the writeback bus
    .clk (clk), .rst_n (rst_n),
    .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
    .rs1_data (rs1_data), .rs2_data (rs2_data),
    .wr_en (wb_valid), .wr_addr (wb_rd), .wr_data (wb_data)
  );

  decode_stage u_decode (
    .clk (clk), .rst_n (rst_n),
    .if_valid (if_valid), .if_instr (if_instr), .if_pc (if_pc),
    .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
    .rs1_data (rs1_data), .rs2_data (rs2_data),
    .ex_valid (ex_valid), .ex_we (ex_we), .ex_rd (ex_rd),
    .id_valid (id_valid), .id_we (id_we), .id_rd (id_rd), .id_pc (id_pc),
    .id_rs1_val (id_rs1_val), .id_rs2_val (id_rs2_val), .id_imm (id_imm),
    .id_a_is_pc (id_a_is_pc), .id_b_is_imm (id_b_is_imm), .id_alu_op (id_alu_op),
    .id_fwd_a (id_fwd_a), .id_fwd_b (id_fwd_b)
  );

  issue_stage u_issue (
    .clk (clk), .rst_n (rst_n),
    .id_valid (id_valid), .id_we (id_we), .id_rd (id_rd), .id_pc (id_pc),
    .id_rs1_val (id_rs1_val), .id_rs2_val (id_rs2_val), .id_imm (id_imm),
    .id_a_is_pc (id_a_is_pc), .id_b_is_imm (id_b_is_imm), .id_alu_op (id_alu_op),
    .id_fwd_a (id_fwd_a), .id_fwd_b (id_fwd_b),
    .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
    .ex_valid (ex_valid), .ex_we (ex_we), .ex_rd (ex_rd), .ex_pc (ex_pc),
    .ex_a (ex_a), .ex_b (ex_b), .ex_alu_op (ex_alu_op),
    .ex_fwd_a (ex_fwd_a), .ex_fwd_b (ex_fwd_b)
  );

  exec_stage u_exec (    // Drives the retirement outputs
    .clk (clk), .rst_n (rst_n),
    .ex_valid (ex_valid), .ex_we (ex_we), .ex_rd (ex_rd), .ex_pc (ex_pc),
    .ex_a (ex_a), .ex_b (ex_b), .ex_alu_op (ex_alu_op),
    .ex_fwd_a (ex_fwd_a), .ex_fwd_b (ex_fwd_b),
    .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data), .wb_pc (wb_pc)
  );

endmodule

// File: tb/clock_gen.sv
// Testbench clock and reset, 4 ns period
// rst_n is held low for 4 rising edges and released on a falling edge

`timescale 1ns/10ps

module clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 250 MHz
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);          // Release away from the sampling edge
    rst_n = 1'b1;
  end

endmodule

// File: tb/core101_checker.sv
// Reference ISA model and in-order retirement compare for core101
// Runs the whole program up front and queues the expected (pc, rd, data)
// DUT ports are sampled on the falling edge, halt and rst_n on the rising edge
// Only OP, OP-IMM, LUI and AUIPC are modelled

`timescale 1ns/10ps
`include "core101_defines.svh"

module core101_checker #(
  parameter int PROG_LEN = 200
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        halt,
  input  logic [31:0] imem_addr,
  input  logic        wb_valid,
  input  logic [4:0]  wb_rd,
  input  logic [31:0] wb_data,
  input  logic [31:0] wb_pc,
  input  logic [31:0] prog [PROG_LEN],
  input  logic        prog_ready,
  output logic        done,        // Every expected retirement seen
  output int          pending,
  output int          val_errs,
  output int          seq_errs,
  output int          proto_errs
);

  localparam int PIPE_FILL = 4;  // Register stages between fetch and writeback

  logic [31:0] exp_pc [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] regs [32];        // Architectural register model
  logic [31:0] last_addr;
  logic        built = 1'b0;
  logic        halt_q = 1'b0;
  logic        rst_q = 1'b0;
  int          edges = 0;
  int          run_edges = 0;    // Edges since reset release

  // RV32I result for one instruction, x1 and x2 are the source values
  function automatic logic [31:0] isa_result(input logic [31:0] ins, input logic [31:0] pc,
                                             input logic [31:0] x1, input logic [31:0] x2);
    logic [31:0] b;
    logic        rtype;
    rtype = (ins[6:0] == `CORE101_OPC_OP);
    b     = rtype ? x2 : {{20{ins[31]}}, ins[31:20]};
    if (ins[6:0] == `CORE101_OPC_LUI)   return {ins[31:12], 12'b0};
    if (ins[6:0] == `CORE101_OPC_AUIPC) return pc + {ins[31:12], 12'b0};
    case (ins[14:12])
      3'b000:  return (rtype && ins[30]) ? x1 - b : x1 + b;  // sub only for OP
      3'b001:  return x1 << b[4:0];
      3'b010:  return ($signed(x1) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (x1 < b) ? 32'd1 : 32'd0;
      3'b100:  return x1 ^ b;
      3'b101:  return ins[30] ? 32'($signed(x1) >>> b[4:0]) : x1 >> b[4:0];
      3'b110:  return x1 | b;
      default: return x1 & b;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Sequential run of the program
  // ------------------------------------------------------------
  initial begin : build
    logic [31:0] ins;
    logic [31:0] res;
    logic [4:0]  rd;
    val_errs   = 0;
    seq_errs   = 0;
    proto_errs = 0;
    pending    = 0;
    done       = 1'b0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    wait (prog_ready);
    for (int i = 0; i < PROG_LEN; i++) begin
      ins = prog[i];
      rd  = ins[11:7];
      res = isa_result(ins, 32'(i * 4), regs[ins[19:15]], regs[ins[24:20]]);
      if (rd != 5'd0) begin                // x0 writes never retire
        regs[rd] = res;
        exp_pc.push_back(32'(i * 4));
        exp_rd.push_back(rd);
        exp_data.push_back(res);
      end
    end
    pending = exp_pc.size();
    done    = (pending == 0);
    built   = 1'b1;
  end

  always @(posedge clk) begin
    halt_q    <= halt;
    rst_q     <= rst_n;
    edges     <= edges + 1;
    run_edges <= rst_n ? run_edges + 1 : 0;
  end

  // ------------------------------------------------------------
  // Mid-cycle checks
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (edges > 0 && (!rst_q || run_edges < PIPE_FILL) && wb_valid !== 1'b0) begin
      $display("Retirement at %0t while the pipeline was in reset or still filling", $time);
      proto_errs++;
    end
    if (edges > 1 && rst_q && halt_q && imem_addr !== last_addr) begin
      $display("** Error at %0t: imem_addr moved from %h to %h while halted",
               $time, last_addr, imem_addr);
      val_errs++;
    end
    last_addr = imem_addr;
    if (wb_valid === 1'b1 && wb_rd == 5'd0) begin
      $display("Write to x0 shown on the writeback port at %0t", $time);
      proto_errs++;
    end
    if (built && rst_q && wb_valid === 1'b1) begin
      if (exp_pc.size() == 0) begin
        $display("Extra retirement at %0t: pc %h x%0d after the last expected one",
                 $time, wb_pc, wb_rd);
        seq_errs++;
      end else begin
        if (wb_pc !== exp_pc[0] || wb_rd !== exp_rd[0] || wb_data !== exp_data[0]) begin
          $display("** Error at %0t: retired pc %h x%0d = %h, expected pc %h x%0d = %h",
                   $time, wb_pc, wb_rd, wb_data, exp_pc[0], exp_rd[0], exp_data[0]);
          val_errs++;
        end
        void'(exp_pc.pop_front());
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
        pending = exp_pc.size();
        done    = (pending == 0);
      end
    end
  end

endmodule

// File: tb/core101_tb.sv
// Testbench top for core101
// 200 random OP, OP-IMM, LUI and AUIPC words using x0..x7 only
// Addresses past the program read back as the NOP
// Inputs change on the falling edge and halt runs cover about a fifth of the cycles

`timescale 1ns/10ps
`include "core101_defines.svh"

module core101_tb;

  localparam int PROG_LEN   = 200;
  localparam int PIPE_DEPTH = 5;
  localparam int TIMEOUT    = 4 * PROG_LEN + PIPE_DEPTH + 100;
  localparam int DRAIN      = 20;  // Cycles of NOPs to expose stray retirements

  logic        clk, rst_n;
  logic        halt = 1'b0;
  logic [31:0] imem_data = `CORE101_NOP;
  logic [31:0] imem_addr, wb_data, wb_pc;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] prog [PROG_LEN];
  logic        prog_ready = 1'b0;
  logic        chk_done;
  int          pending, val_errs, seq_errs, proto_errs;
  int          cycle_cnt = 0;
  int          halt_left = 0;    // Remaining cycles of the current halt run
  logic        timed_out = 1'b0;

  clock_gen u_clk (.clk (clk), .rst_n (rst_n));

  core101_top UUT (
    .clk (clk), .rst_n (rst_n), .halt (halt),
    .imem_data (imem_data), .imem_addr (imem_addr),
    .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data), .wb_pc (wb_pc)
  );

  core101_checker #(.PROG_LEN (PROG_LEN)) u_chk (
    .clk (clk), .rst_n (rst_n), .halt (halt), .imem_addr (imem_addr),
    .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data), .wb_pc (wb_pc),
    .prog (prog), .prog_ready (prog_ready),
    .done (chk_done), .pending (pending),
    .val_errs (val_errs), .seq_errs (seq_errs), .proto_errs (proto_errs)
  );

  // One random instruction from the supported groups
  function automatic logic [31:0] rand_instr();
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [19:0] imm20;
    int          kind;
    rd    = 5'($urandom_range(7));   // Small register set for dense hazards
    rs1   = 5'($urandom_range(7));
    rs2   = 5'($urandom_range(7));
    f3    = 3'($urandom_range(7));
    f7    = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1) == 1) ? 7'b0100000 : 7'b0;
    imm12 = 12'($urandom);
    imm20 = 20'($urandom);
    kind  = $urandom_range(9);
    if (kind < 4) return {f7, rs2, rs1, f3, rd, `CORE101_OPC_OP};
    if (kind < 8) begin
      if (f3 == 3'b001)      imm12 = {7'b0, imm12[4:0]};  // slli
      else if (f3 == 3'b101) imm12 = {f7, imm12[4:0]};    // srli or srai
      return {imm12, rs1, f3, rd, `CORE101_OPC_OP_IMM};
    end
    if (kind == 8) return {imm20, rd, `CORE101_OPC_LUI};
    return {imm20, rd, `CORE101_OPC_AUIPC};
  endfunction

  // Instruction memory model
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    int idx;
    idx = int'(addr >> 2);
    if (idx < PROG_LEN) return prog[idx];
    return `CORE101_NOP;
  endfunction

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ------------------------------------------------------------
  // Stimulus on the falling edge
  // ------------------------------------------------------------
  always @(negedge clk) begin
    if (prog_ready) imem_data = fetch_word(imem_addr);
    if (cycle_cnt > 4) begin             // Quiet through reset
      if (halt_left > 0) begin
        halt = 1'b1;
        halt_left--;
      end else if ($urandom_range(99) < 7) begin
        halt      = 1'b1;
        halt_left = $urandom_range(5);   // Runs of 1 to 6 cycles
      end else begin
        halt = 1'b0;
      end
    end
  end

  initial begin : main
    int missing;
    int total;
    void'($urandom(94733));
    for (int i = 0; i < PROG_LEN; i++) prog[i] = rand_instr();
    prog_ready = 1'b1;
    while (!chk_done && cycle_cnt < TIMEOUT) @(posedge clk);
    if (!chk_done) begin
      timed_out = 1'b1;
      $display("Timeout after %0d cycles with %0d expected retirements never seen",
               cycle_cnt, pending);
    end else begin
      repeat (DRAIN) @(posedge clk);
    end
    missing = timed_out ? pending : 0;
    total   = val_errs + seq_errs + proto_errs + missing;
    $display("Error counts: value %0d, sequence %0d, protocol %0d, missing %0d",
             val_errs, seq_errs, proto_errs, missing);
    if (total == 0 && !timed_out) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: core101.f
+incdir+src
src/core101_pkg.sv
src/fetch_unit.sv
src/gpr_file.sv
src/forward_unit.sv
src/decode_stage.sv
src/issue_stage.sv
src/exec_stage.sv
src/core101_top.sv
tb/clock_gen.sv
tb/core101_checker.sv
tb/core101_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build core101 with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 --top-module core101_tb \
    -f core101.f -o core101_sim \
  && ./obj_dir/core101_sim > "$LOG" 2>&1 \
  || echo "Build or simulation returned an error"

cat "$LOG" 2>/dev/null

grep -qx "TB PASSED" "$LOG" \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }
